// ==== sim.f ====
+incdir+include
hw/procyon_types_pkg.sv
hw/wb_types_pkg.sv
hw/mhq_entries.sv
hw/fill_line_buffer.sv
hw/wb_read_fsm.sv
hw/wb_beat_counter.sv
hw/ccu.sv
dv/ccu_checker.sv
dv/tb_ccu.sv

// ==== Makefile ====
VERILATOR ?= verilator
TOP       ?= tb_ccu
FILELIST  ?= sim.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing -j 0

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	grep -q "SIMULATION PASSED" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// ==== dv/tb_ccu.sv ====
`default_nettype none

`include "procyon_config.svh"

module tb_ccu
    import procyon_types_pkg::*;
    import wb_types_pkg::*;
();

    localparam int CLK_PERIOD    = 100;
    localparam int DRIVE_DELAY   = 10;
    localparam int NUM_ROWS      = 14;
    localparam int EXP_RESULTS   = 14;
    localparam int FULL_TIMEOUT  = 20;
    localparam int SPACE_TIMEOUT = 500;
    localparam int DRAIN_TIMEOUT = 2000;
    localparam procyon_data_t MEM_PATTERN = 32'hA5C3_0F96;

    typedef struct packed {
        logic [8*12-1:0]        name;
        logic                   we;
        procyon_addr_t          addr;
        procyon_data_t          data;
        procyon_byte_select_t   byte_select;
        procyon_mhq_tag_t       tag;
        logic                   hold;
        logic                   last;
    } test_row_t;

    logic                   clk;
    logic                   rst_n;
    logic                   enq_en;
    logic                   enq_we;
    procyon_addr_t          enq_addr;
    procyon_data_t          enq_data;
    procyon_byte_select_t   enq_bsel;
    procyon_mhq_tag_t       enq_tag;
    logic                   full;
    logic                   fill;
    procyon_mhq_tag_t       fill_tag;
    logic                   fill_dirty;
    procyon_addr_t          fill_addr;
    procyon_cacheline_t     fill_data;
    logic                   wb_ack;
    logic                   wb_stall;
    wb_data_t               wb_data;
    logic                   wb_cyc;
    logic                   wb_stb;
    wb_addr_t               wb_addr;

    logic [8*12-1:0]        test_name;
    procyon_mhq_tag_t       exp_tag;
    logic                   check_idle;
    logic                   bus_hold;
    logic [31:0]            rng_state;
    wb_addr_t               bus_q[$];
    test_row_t              rows [0:NUM_ROWS-1];
    int                     pending;
    int                     pass_count;
    int                     fail_count;
    int                     tb_errors;

    ccu UUT (
        .i_clk(clk),
        .i_rst_n(rst_n),
        .i_mhq_enq_en(enq_en),
        .i_mhq_enq_we(enq_we),
        .i_mhq_enq_addr(enq_addr),
        .i_mhq_enq_data(enq_data),
        .i_mhq_enq_byte_select(enq_bsel),
        .o_mhq_enq_tag(enq_tag),
        .o_mhq_full(full),
        .o_mhq_fill(fill),
        .o_mhq_fill_tag(fill_tag),
        .o_mhq_fill_dirty(fill_dirty),
        .o_mhq_fill_addr(fill_addr),
        .o_mhq_fill_data(fill_data),
        .i_wb_ack(wb_ack),
        .i_wb_stall(wb_stall),
        .i_wb_data(wb_data),
        .o_wb_cyc(wb_cyc),
        .o_wb_stb(wb_stb),
        .o_wb_addr(wb_addr)
    );

    ccu_checker #(.MEM_PATTERN(MEM_PATTERN)) checker_inst (
        .i_clk(clk),
        .i_rst_n(rst_n),
        .i_test_name(test_name),
        .i_exp_tag(exp_tag),
        .i_check_idle(check_idle),
        .i_enq_en(enq_en),
        .i_enq_we(enq_we),
        .i_enq_addr(enq_addr),
        .i_enq_data(enq_data),
        .i_enq_byte_select(enq_bsel),
        .i_enq_tag(enq_tag),
        .i_full(full),
        .i_fill(fill),
        .i_fill_tag(fill_tag),
        .i_fill_dirty(fill_dirty),
        .i_fill_addr(fill_addr),
        .i_fill_data(fill_data),
        .i_wb_cyc(wb_cyc),
        .i_wb_stb(wb_stb),
        .o_pending(pending),
        .o_pass_count(pass_count),
        .o_fail_count(fail_count)
    );

    function automatic logic [31:0] xorshift32(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    function automatic test_row_t make_row(input logic [8*12-1:0] name, input logic we,
                                           input procyon_addr_t addr, input procyon_data_t data,
                                           input procyon_byte_select_t bsel,
                                           input procyon_mhq_tag_t tag,
                                           input logic hold, input logic last);
        test_row_t row;
        row.name        = name;
        row.we          = we;
        row.addr        = addr;
        row.data        = data;
        row.byte_select = bsel;
        row.tag         = tag;
        row.hold        = hold;
        row.last        = last;
        return row;
    endfunction

    // Rows flagged last wait for the queue to drain
    // Hold keeps the bus stalled
    task automatic load_table();
        rows[0]  = make_row("load_miss", 1'b0, 32'h0000_1004, 32'h0, 4'h0, 2'd0, 1'b0, 1'b1);
        rows[1]  = make_row("store_miss", 1'b1, 32'h0000_2008, 32'hDEAD_BEEF, 4'h6, 2'd1,
                            1'b0, 1'b1);
        rows[2]  = make_row("merge", 1'b1, 32'h0000_3000, 32'h1122_3344, 4'hF, 2'd2, 1'b0, 1'b0);
        rows[3]  = make_row("merge", 1'b1, 32'h0000_300C, 32'h5566_7788, 4'h9, 2'd2, 1'b0, 1'b1);
        rows[4]  = make_row("full_0", 1'b0, 32'h0000_4000, 32'h0, 4'h0, 2'd3, 1'b1, 1'b0);
        rows[5]  = make_row("full_1", 1'b0, 32'h0000_4010, 32'h0, 4'h0, 2'd0, 1'b1, 1'b0);
        rows[6]  = make_row("full_2", 1'b1, 32'h0000_4024, 32'hCAFE_F00D, 4'h3, 2'd1, 1'b1, 1'b0);
        rows[7]  = make_row("full_3", 1'b0, 32'h0000_4030, 32'h0, 4'h0, 2'd2, 1'b1, 1'b1);
        rows[8]  = make_row("random_0", 1'b0, 32'h0001_0000, 32'h0, 4'h0, 2'd3, 1'b0, 1'b0);
        rows[9]  = make_row("random_1", 1'b1, 32'h0001_0018, 32'h0BAD_C0DE, 4'hC, 2'd0,
                            1'b0, 1'b0);
        rows[10] = make_row("random_2", 1'b0, 32'h0001_0020, 32'h0, 4'h0, 2'd1, 1'b0, 1'b0);
        rows[11] = make_row("random_3", 1'b1, 32'h0001_0034, 32'h1234_5678, 4'h1, 2'd2,
                            1'b0, 1'b0);
        rows[12] = make_row("random_4", 1'b0, 32'h0001_0040, 32'h0, 4'h0, 2'd3, 1'b0, 1'b0);
        rows[13] = make_row("random_5", 1'b0, 32'h0001_005C, 32'h0, 4'h0, 2'd0, 1'b0, 1'b1);
    endtask

    task automatic wait_not_full(output logic ok);
        int cycles;
        cycles = 0;
        while (full && cycles < SPACE_TIMEOUT) begin
            @(posedge clk);
            #DRIVE_DELAY;
            cycles++;
        end
        ok = !full;
        if (!ok) begin
            $display("ERROR: queue stayed full for %0d cycles", SPACE_TIMEOUT);
            tb_errors++;
        end
    endtask

    task automatic wait_full(output logic ok);
        int cycles;
        cycles = 0;
        while (!full && cycles < FULL_TIMEOUT) begin
            @(posedge clk);
            #DRIVE_DELAY;
            cycles++;
        end
        ok = full;
        if (!ok) begin
            $display("ERROR: queue did not report full with the bus stalled");
            tb_errors++;
        end
    endtask

    task automatic wait_drained(output logic ok);
        int cycles;
        cycles = 0;
        while (pending != 0 && cycles < DRAIN_TIMEOUT) begin
            @(posedge clk);
            #DRIVE_DELAY;
            cycles++;
        end
        ok = (pending == 0);
        if (!ok) begin
            $display("ERROR: %0d misses still waiting for a fill after %0d cycles",
                     pending, DRAIN_TIMEOUT);
            tb_errors++;
        end
    endtask

    task automatic apply_row(input test_row_t row, output logic ok);
        wait_not_full(ok);
        if (ok) begin
            bus_hold  = row.hold;
            test_name = row.name;
            exp_tag   = row.tag;
            enq_we    = row.we;
            enq_addr  = row.addr;
            enq_data  = row.data;
            enq_bsel  = row.byte_select;
            enq_en    = 1'b1;
            @(posedge clk);
            #DRIVE_DELAY;
            enq_en = 1'b0;
            if (row.last && row.hold) begin
                wait_full(ok);
                bus_hold = 1'b0;
            end
            if (ok && row.last) begin
                wait_drained(ok);
            end
        end
    endtask

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD/2) clk = ~clk;
    end

    // Pipelined slave returning each word as its address XOR the pattern
    initial begin : bus_model
        logic       accept_seen;
        logic       ack_seen;
        logic       hold_seen;
        wb_addr_t   addr_seen;
        wb_ack    = 1'b0;
        wb_stall  = 1'b0;
        wb_data   = '0;
        rng_state = 32'd63;
        forever begin
            @(negedge clk);
            accept_seen = rst_n && wb_stb && !wb_stall;
            ack_seen    = wb_ack;
            addr_seen   = wb_addr;
            hold_seen   = bus_hold;
            @(posedge clk);
            #DRIVE_DELAY;
            if (!rst_n) begin
                bus_q.delete();
            end
            if (ack_seen) begin
                void'(bus_q.pop_front());
            end
            if (accept_seen) begin
                bus_q.push_back(addr_seen);
            end
            rng_state = xorshift32(rng_state);
            wb_stall  = hold_seen || (rng_state[1:0] == 2'b00);
            wb_ack    = (bus_q.size() > 0) && (rng_state[3:2] != 2'b00);
            if (wb_ack) begin
                wb_data = bus_q[0] ^ MEM_PATTERN;
            end else begin
                wb_data = '0;
            end
        end
    end

    initial begin : stimulus
        logic ok;
        rst_n      = 1'b0;
        enq_en     = 1'b0;
        enq_we     = 1'b0;
        enq_addr   = '0;
        enq_data   = '0;
        enq_bsel   = '0;
        check_idle = 1'b0;
        bus_hold   = 1'b0;
        test_name  = "reset_idle";
        exp_tag    = '0;
        tb_errors  = 0;
        ok         = 1'b1;
        load_table();
        repeat (5) @(posedge clk);
        #DRIVE_DELAY;
        rst_n      = 1'b1;
        check_idle = 1'b1;
        @(posedge clk);
        #DRIVE_DELAY;
        check_idle = 1'b0;
        for (int i = 0; i < NUM_ROWS && ok; i++) begin
            apply_row(rows[i], ok);
        end
        @(posedge clk);
        #DRIVE_DELAY;
        if (pass_count + fail_count != EXP_RESULTS) begin
            $display("ERROR: expected %0d results but the checker reported %0d",
                     EXP_RESULTS, pass_count + fail_count);
            tb_errors++;
        end
        $display("Results: %0d passed, %0d failed, %0d testbench errors",
                 pass_count, fail_count, tb_errors);
        if (tb_errors == 0 && fail_count == 0 && pass_count == EXP_RESULTS) begin
            $display("SIMULATION PASSED");
        end else begin
            $display("SIMULATION FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== dv/ccu_checker.sv ====
`default_nettype none

`include "procyon_config.svh"

module ccu_checker
    import procyon_types_pkg::*;
#(
    parameter procyon_data_t MEM_PATTERN = 32'h0
)
(
    input  logic                    i_clk,
    input  logic                    i_rst_n,
    input  logic [8*12-1:0]         i_test_name,
    input  procyon_mhq_tag_t        i_exp_tag,
    input  logic                    i_check_idle,
    input  logic                    i_enq_en,
    input  logic                    i_enq_we,
    input  procyon_addr_t           i_enq_addr,
    input  procyon_data_t           i_enq_data,
    input  procyon_byte_select_t    i_enq_byte_select,
    input  procyon_mhq_tag_t        i_enq_tag,
    input  logic                    i_full,
    input  logic                    i_fill,
    input  procyon_mhq_tag_t        i_fill_tag,
    input  logic                    i_fill_dirty,
    input  procyon_addr_t           i_fill_addr,
    input  procyon_cacheline_t      i_fill_data,
    input  logic                    i_wb_cyc,
    input  logic                    i_wb_stb,
    output int                      o_pending,
    output int                      o_pass_count,
    output int                      o_fail_count
);

    localparam int LINE_BYTES = `DCACHE_LINE_WIDTH / 8;
    localparam int WORD_BYTES = `DATA_WIDTH / 8;

    // What the next fill of one entry should look like
    typedef struct packed {
        logic [8*12-1:0]        name;
        procyon_mhq_tag_t       tag;
        procyon_addr_t          addr;
        logic                   dirty;
        procyon_cacheline_t     line;
    } expect_t;

    expect_t            pending_q[$];
    procyon_mhq_tag_t   next_tag;
    logic               exp_full;
    int                 pending_count;
    int                 pass_count;
    int                 fail_count;

    assign o_pending    = pending_count;
    assign o_pass_count = pass_count;
    assign o_fail_count = fail_count;

    function automatic procyon_cacheline_t memory_line(input procyon_addr_t line_addr);
        procyon_cacheline_t line;
        for (int k = 0; k < LINE_BYTES / WORD_BYTES; k++) begin
            line[k*`DATA_WIDTH +: `DATA_WIDTH] = (line_addr + 32'(k * WORD_BYTES)) ^ MEM_PATTERN;
        end
        return line;
    endfunction

    function automatic procyon_cacheline_t apply_store(input procyon_cacheline_t line,
                                                       input procyon_addr_t addr,
                                                       input procyon_data_t data,
                                                       input procyon_byte_select_t bsel);
        procyon_cacheline_t result;
        int word;
        result = line;
        word = int'(addr[3:2]);
        for (int j = 0; j < WORD_BYTES; j++) begin
            if (bsel[j]) begin
                result[(word*WORD_BYTES+j)*8 +: 8] = data[j*8 +: 8];
            end
        end
        return result;
    endfunction

    task automatic record_enqueue();
        expect_t entry;
        procyon_addr_t line_addr;
        int match;
        line_addr = i_enq_addr & ~procyon_addr_t'(LINE_BYTES - 1);
        match = -1;
        // The head line stops taking merges once its fill is out
        for (int i = 0; i < pending_q.size(); i++) begin
            if (pending_q[i].addr == line_addr && !(i_fill && i == 0)) begin
                match = i;
            end
        end
        if (i_enq_tag !== i_exp_tag) begin
            $display("FAIL %0s enqueue tag expected %0d actual %0d",
                     i_test_name, i_exp_tag, i_enq_tag);
            fail_count++;
        end
        if (match >= 0) begin
            entry = pending_q[match];
        end else begin
            entry.name  = i_test_name;
            entry.tag   = next_tag;
            entry.addr  = line_addr;
            entry.dirty = 1'b0;
            entry.line  = memory_line(line_addr);
        end
        entry.dirty = entry.dirty | i_enq_we;
        if (i_enq_we) begin
            entry.line = apply_store(entry.line, i_enq_addr, i_enq_data, i_enq_byte_select);
        end
        if (match >= 0) begin
            pending_q[match] = entry;
        end else begin
            pending_q.push_back(entry);
            next_tag = next_tag + procyon_mhq_tag_t'(1);
        end
    endtask

    task automatic check_fill();
        expect_t want;
        if (pending_q.size() == 0) begin
            $display("FAIL fill with tag %0d arrived while no request was pending", i_fill_tag);
            fail_count++;
            return;
        end
        want = pending_q.pop_front();
        if (i_fill_tag === want.tag && i_fill_addr === want.addr &&
            i_fill_dirty === want.dirty && i_fill_data === want.line) begin
            $display("PASS %0s tag %0d addr %h dirty %b", want.name, want.tag, want.addr,
                     want.dirty);
            pass_count++;
        end else begin
            $write("FAIL %0s expected tag %0d addr %h dirty %b data %h",
                   want.name, want.tag, want.addr, want.dirty, want.line);
            $display(" actual tag %0d addr %h dirty %b data %h",
                     i_fill_tag, i_fill_addr, i_fill_dirty, i_fill_data);
            fail_count++;
        end
    endtask

    // Sampled mid cycle away from the edge where inputs change
    always @(negedge i_clk) begin
        if (!i_rst_n) begin
            pending_q.delete();
            next_tag   = '0;
            pass_count = 0;
            fail_count = 0;
        end else begin
            exp_full = (pending_q.size() == `MHQ_DEPTH);
            if (i_full !== exp_full) begin
                $display("FAIL %0s full flag expected %b actual %b",
                         i_test_name, exp_full, i_full);
                fail_count++;
            end
            if (i_check_idle) begin
                if ({i_wb_cyc, i_wb_stb, i_fill, i_full} !== 4'b0000) begin
                    $display("FAIL %0s cyc/stb/fill/full expected 0000 actual %b%b%b%b",
                             i_test_name, i_wb_cyc, i_wb_stb, i_fill, i_full);
                    fail_count++;
                end else begin
                    $display("PASS %0s", i_test_name);
                    pass_count++;
                end
            end
            if (i_enq_en && !i_full) begin
                record_enqueue();
            end
            if (i_fill) begin
                check_fill();
            end
        end
        pending_count = pending_q.size();
    end

endmodule

`default_nettype wire

// ==== hw/ccu.sv ====
`default_nettype none

`include "procyon_config.svh"

module ccu
    import procyon_types_pkg::*;
    import wb_types_pkg::*;
(
    input  logic                    i_clk,
    input  logic                    i_rst_n,

    // Load/store unit miss requests
    input  logic                    i_mhq_enq_en,
    input  logic                    i_mhq_enq_we,
    input  procyon_addr_t           i_mhq_enq_addr,
    input  procyon_data_t           i_mhq_enq_data,
    input  procyon_byte_select_t    i_mhq_enq_byte_select,
    output procyon_mhq_tag_t        o_mhq_enq_tag,
    output logic                    o_mhq_full,

    // Line fills back to the load/store unit
    output logic                    o_mhq_fill,
    output procyon_mhq_tag_t        o_mhq_fill_tag,
    output logic                    o_mhq_fill_dirty,
    output procyon_addr_t           o_mhq_fill_addr,
    output procyon_cacheline_t      o_mhq_fill_data,

    // Wishbone read master
    input  logic                    i_wb_ack,
    input  logic                    i_wb_stall,
    input  wb_data_t                i_wb_data,
    output logic                    o_wb_cyc,
    output logic                    o_wb_stb,
    output wb_addr_t                o_wb_addr
);

    localparam int LINE_OFFSET_BITS = $clog2(`DCACHE_LINE_WIDTH / 8);
    localparam int WB_BYTE_BITS     = $clog2(`WB_DATA_WIDTH / 8);

    mhq_entry_t         head_entry;
    procyon_mhq_tag_t   head_tag;
    logic               head_valid;
    logic               head_busy;
    logic               fill;
    logic               release_head;
    wb_beat_t           req_beat;
    wb_beat_t           ack_beat;
    logic               last_req;
    logic               last_ack;
    logic               req_accept;
    procyon_cacheline_t fill_data;

    assign req_accept = o_wb_stb & ~i_wb_stall;

    // Beat k sits at line address plus 4k
    assign o_wb_addr = {head_entry.addr[`ADDR_WIDTH-1:LINE_OFFSET_BITS], req_beat,
                        {WB_BYTE_BITS{1'b0}}};

    assign o_mhq_fill       = fill;
    assign o_mhq_fill_tag   = head_tag;
    assign o_mhq_fill_dirty = head_entry.dirty;
    assign o_mhq_fill_addr  = head_entry.addr;
    assign o_mhq_fill_data  = fill_data;

    mhq_entries mhq_entries_inst (
        .i_clk(i_clk),
        .i_rst_n(i_rst_n),
        .i_enq_en(i_mhq_enq_en),
        .i_enq_we(i_mhq_enq_we),
        .i_enq_addr(i_mhq_enq_addr),
        .i_enq_data(i_mhq_enq_data),
        .i_enq_byte_select(i_mhq_enq_byte_select),
        .i_head_busy(head_busy),
        .i_release(release_head),
        .o_enq_tag(o_mhq_enq_tag),
        .o_full(o_mhq_full),
        .o_head_valid(head_valid),
        .o_head_tag(head_tag),
        .o_head_entry(head_entry)
    );

    wb_read_fsm wb_read_fsm_inst (
        .i_clk(i_clk),
        .i_rst_n(i_rst_n),
        .i_head_valid(head_valid),
        .i_wb_stall(i_wb_stall),
        .i_wb_ack(i_wb_ack),
        .i_last_req(last_req),
        .i_last_ack(last_ack),
        .o_wb_cyc(o_wb_cyc),
        .o_wb_stb(o_wb_stb),
        .o_head_busy(head_busy),
        .o_fill(fill),
        .o_release(release_head)
    );

    wb_beat_counter wb_beat_counter_inst (
        .i_clk(i_clk),
        .i_rst_n(i_rst_n),
        .i_req_accept(req_accept),
        .i_ack(i_wb_ack),
        .i_clear(fill),
        .o_req_beat(req_beat),
        .o_ack_beat(ack_beat),
        .o_last_req(last_req),
        .o_last_ack(last_ack)
    );

    fill_line_buffer fill_line_buffer_inst (
        .i_clk(i_clk),
        .i_rst_n(i_rst_n),
        .i_ack(i_wb_ack),
        .i_ack_beat(ack_beat),
        .i_wb_data(i_wb_data),
        .i_head_entry(head_entry),
        .o_fill_data(fill_data)
    );

endmodule

`default_nettype wire

// ==== hw/wb_beat_counter.sv ====
`default_nettype none

`include "procyon_config.svh"

module wb_beat_counter
    import wb_types_pkg::*;
(
    input  logic        i_clk,
    input  logic        i_rst_n,

    input  logic        i_req_accept,
    input  logic        i_ack,
    input  logic        i_clear,

    output wb_beat_t    o_req_beat,
    output wb_beat_t    o_ack_beat,
    output logic        o_last_req,
    output logic        o_last_ack
);

    localparam wb_beat_t LAST_BEAT = wb_beat_t'(`WB_BEATS - 1);

    wb_beat_t req_beat;
    wb_beat_t ack_beat;

    // Acks trail the requests and count on their own
    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            req_beat <= '0;
            ack_beat <= '0;
        end else if (i_clear) begin
            req_beat <= '0;
            ack_beat <= '0;
        end else begin
            if (i_req_accept) begin
                req_beat <= req_beat + 1'b1;
            end
            if (i_ack) begin
                ack_beat <= ack_beat + 1'b1;
            end
        end
    end

    assign o_req_beat = req_beat;
    assign o_ack_beat = ack_beat;
    assign o_last_req = (req_beat == LAST_BEAT);
    assign o_last_ack = (ack_beat == LAST_BEAT);

endmodule

`default_nettype wire

// ==== hw/wb_read_fsm.sv ====
`default_nettype none

module wb_read_fsm
    import wb_types_pkg::*;
(
    input  logic    i_clk,
    input  logic    i_rst_n,

    input  logic    i_head_valid,
    input  logic    i_wb_stall,
    input  logic    i_wb_ack,
    input  logic    i_last_req,
    input  logic    i_last_ack,

    output logic    o_wb_cyc,
    output logic    o_wb_stb,

    output logic    o_head_busy,
    output logic    o_fill,
    output logic    o_release
);

    wb_state_t state;
    wb_state_t state_next;

    always_comb begin
        state_next = state;
        case (state)
            IDLE: begin
                if (i_head_valid) begin
                    state_next = REQ;
                end
            end
            // Leave once the final beat is taken by the slave
            REQ: begin
                if (!i_wb_stall && i_last_req) begin
                    state_next = WAIT_ACK;
                end
            end
            WAIT_ACK: begin
                if (i_wb_ack && i_last_ack) begin
                    state_next = FILL;
                end
            end
            FILL: begin
                state_next = IDLE;
            end
            default: begin
                state_next = IDLE;
            end
        endcase
    end

    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            state <= IDLE;
        end else begin
            state <= state_next;
        end
    end

    assign o_wb_cyc    = (state == REQ) || (state == WAIT_ACK);
    assign o_wb_stb    = (state == REQ);

    // Fill goes out and the head is freed on the same cycle
    assign o_head_busy = (state == FILL);
    assign o_fill      = (state == FILL);
    assign o_release   = (state == FILL);

endmodule

`default_nettype wire

// ==== hw/fill_line_buffer.sv ====
`default_nettype none

`include "procyon_config.svh"

module fill_line_buffer
    import procyon_types_pkg::*;
    import wb_types_pkg::*;
(
    input  logic                i_clk,
    input  logic                i_rst_n,

    input  logic                i_ack,
    input  wb_beat_t            i_ack_beat,
    input  wb_data_t            i_wb_data,

    input  mhq_entry_t          i_head_entry,
    output procyon_cacheline_t  o_fill_data
);

    localparam int LINE_BYTES = `DCACHE_LINE_WIDTH / 8;

    procyon_cacheline_t line_q;

    // Each ack returns one word in request order
    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            line_q <= '0;
        end else if (i_ack) begin
            line_q[i_ack_beat*`WB_DATA_WIDTH +: `WB_DATA_WIDTH] <= i_wb_data;
        end
    end

    // Pending store bytes win over memory
    always_comb begin
        for (int b = 0; b < LINE_BYTES; b++) begin
            if (i_head_entry.mask[b]) begin
                o_fill_data[b*8 +: 8] = i_head_entry.data[b*8 +: 8];
            end else begin
                o_fill_data[b*8 +: 8] = line_q[b*8 +: 8];
            end
        end
    end

endmodule

`default_nettype wire

// ==== hw/mhq_entries.sv ====
`default_nettype none

`include "procyon_config.svh"

module mhq_entries
    import procyon_types_pkg::*;
(
    input  logic                    i_clk,
    input  logic                    i_rst_n,

    input  logic                    i_enq_en,
    input  logic                    i_enq_we,
    input  procyon_addr_t           i_enq_addr,
    input  procyon_data_t           i_enq_data,
    input  procyon_byte_select_t    i_enq_byte_select,

    input  logic                    i_head_busy,
    input  logic                    i_release,

    output procyon_mhq_tag_t        o_enq_tag,
    output logic                    o_full,

    output logic                    o_head_valid,
    output procyon_mhq_tag_t        o_head_tag,
    output mhq_entry_t              o_head_entry
);

    localparam int LINE_BYTES  = `DCACHE_LINE_WIDTH / 8;
    localparam int WORD_BYTES  = `DATA_WIDTH / 8;
    localparam int OFFSET_BITS = $clog2(LINE_BYTES);
    localparam int WORD_BITS   = $clog2(WORD_BYTES);

    logic [`MHQ_DEPTH-1:0]              entry_valid;
    procyon_addr_t                      entry_addr  [0:`MHQ_DEPTH-1];
    logic                               entry_dirty [0:`MHQ_DEPTH-1];
    procyon_cacheline_t                 entry_data  [0:`MHQ_DEPTH-1];
    procyon_line_mask_t                 entry_mask  [0:`MHQ_DEPTH-1];

    procyon_mhq_tag_t                   head;
    procyon_mhq_tag_t                   tail;
    logic [`MHQ_TAG_WIDTH:0]            count;

    procyon_addr_t                      enq_line;
    logic [OFFSET_BITS-WORD_BITS-1:0]   enq_word;
    procyon_cacheline_t                 enq_line_data;
    procyon_line_mask_t                 enq_line_mask;
    logic                               match;
    procyon_mhq_tag_t                   match_tag;
    logic                               accept;
    logic                               alloc;
    procyon_mhq_tag_t                   wr_tag;

    assign enq_line = {i_enq_addr[`ADDR_WIDTH-1:OFFSET_BITS], {OFFSET_BITS{1'b0}}};
    assign enq_word = i_enq_addr[OFFSET_BITS-1:WORD_BITS];

    // Store word and its byte enables moved to their slot in the line
    assign enq_line_data = procyon_cacheline_t'(i_enq_data) << (enq_word * `DATA_WIDTH);
    assign enq_line_mask = i_enq_we ?
                           procyon_line_mask_t'(i_enq_byte_select) << (enq_word * WORD_BYTES) :
                           '0;

    // Any pending entry for this line other than a head whose fill is out
    always_comb begin
        match     = 1'b0;
        match_tag = '0;
        for (int i = 0; i < `MHQ_DEPTH; i++) begin
            if (entry_valid[i] && (entry_addr[i] == enq_line) &&
                !(i_head_busy && (procyon_mhq_tag_t'(i) == head))) begin
                match     = 1'b1;
                match_tag = procyon_mhq_tag_t'(i);
            end
        end
    end

    assign accept    = i_enq_en & ~o_full;
    assign alloc     = accept & ~match;
    assign wr_tag    = match ? match_tag : tail;
    assign o_enq_tag = wr_tag;

    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            entry_valid <= '0;
            head        <= '0;
            tail        <= '0;
            count       <= '0;
        end else begin
            if (alloc) begin
                entry_valid[tail] <= 1'b1;
                tail              <= tail + 1'b1;
            end
            if (i_release) begin
                entry_valid[head] <= 1'b0;
                head              <= head + 1'b1;
            end
            count <= count + {{`MHQ_TAG_WIDTH{1'b0}}, alloc}
                           - {{`MHQ_TAG_WIDTH{1'b0}}, i_release};
        end
    end

    always_ff @(posedge i_clk) begin
        if (accept) begin
            if (alloc) begin
                entry_addr[wr_tag]  <= enq_line;
                entry_dirty[wr_tag] <= i_enq_we;
                entry_mask[wr_tag]  <= enq_line_mask;
            end else begin
                entry_dirty[wr_tag] <= entry_dirty[wr_tag] | i_enq_we;
                entry_mask[wr_tag]  <= entry_mask[wr_tag] | enq_line_mask;
            end
            // Later stores overwrite earlier bytes
            for (int b = 0; b < LINE_BYTES; b++) begin
                if (enq_line_mask[b]) begin
                    entry_data[wr_tag][b*8 +: 8] <= enq_line_data[b*8 +: 8];
                end
            end
        end
    end

    assign o_full       = (count == (`MHQ_TAG_WIDTH+1)'(`MHQ_DEPTH));
    assign o_head_valid = entry_valid[head];
    assign o_head_tag   = head;

    always_comb begin
        o_head_entry.valid = entry_valid[head];
        o_head_entry.addr  = entry_addr[head];
        o_head_entry.dirty = entry_dirty[head];
        o_head_entry.data  = entry_data[head];
        o_head_entry.mask  = entry_mask[head];
    end

endmodule

`default_nettype wire

// ==== hw/wb_types_pkg.sv ====
`default_nettype none

`include "procyon_config.svh"

package wb_types_pkg;

    typedef logic [`ADDR_WIDTH-1:0]         wb_addr_t;
    typedef logic [`WB_DATA_WIDTH-1:0]      wb_data_t;
    typedef logic [$clog2(`WB_BEATS)-1:0]   wb_beat_t;

    typedef enum logic [1:0] {
        IDLE,
        REQ,
        WAIT_ACK,
        FILL
    } wb_state_t;

endpackage

`default_nettype wire

// ==== hw/procyon_types_pkg.sv ====
`default_nettype none

`include "procyon_config.svh"

package procyon_types_pkg;

    typedef logic [`ADDR_WIDTH-1:0]            procyon_addr_t;
    typedef logic [`DATA_WIDTH-1:0]            procyon_data_t;
    typedef logic [`DATA_WIDTH/8-1:0]          procyon_byte_select_t;
    typedef logic [`DCACHE_LINE_WIDTH-1:0]     procyon_cacheline_t;
    typedef logic [`DCACHE_LINE_WIDTH/8-1:0]   procyon_line_mask_t;
    typedef logic [`MHQ_TAG_WIDTH-1:0]         procyon_mhq_tag_t;

    // One pending miss, stores are kept as bytes over the whole line
    typedef struct packed {
        logic                  valid;
        procyon_addr_t         addr;
        logic                  dirty;
        procyon_cacheline_t    data;
        procyon_line_mask_t    mask;
    } mhq_entry_t;

endpackage

`default_nettype wire

// ==== include/procyon_config.svh ====
`ifndef PROCYON_CONFIG_SVH
`define PROCYON_CONFIG_SVH

// Core side
`define DATA_WIDTH          32
`define ADDR_WIDTH          32
`define DCACHE_LINE_WIDTH   128

// Miss handling queue, depth must be a power of two
`define MHQ_DEPTH           4
`define MHQ_TAG_WIDTH       2

// Wishbone side
`define WB_DATA_WIDTH       32
`define WB_BEATS            4

`endif
